// ==== p64_pkg.sv ====
/*
 * 10G receive path shared definitions
 * Block field widths, sync and control type codes, preamble and fault constants
 */
package p64_pkg;

	// Block and beat geometry
	localparam int BLOCK_W = 66;
	localparam int DATA_W  = 64;
	// Zero here means a full beat of eight bytes
	localparam int BYTES_W = 3;

	// Sync header
	typedef logic [1:0] sync_t;
	localparam sync_t SYNC_CONTROL = 2'b01;
	localparam sync_t SYNC_DATA    = 2'b10;

	// Control block type codes
	typedef logic [7:0] ctrl_type_t;
	localparam ctrl_type_t CT_START = 8'h78;
	localparam ctrl_type_t CT_TERM0 = 8'h87;
	localparam ctrl_type_t CT_TERM1 = 8'h99;
	localparam ctrl_type_t CT_TERM2 = 8'haa;
	localparam ctrl_type_t CT_TERM3 = 8'hb4;
	localparam ctrl_type_t CT_TERM4 = 8'hcc;
	localparam ctrl_type_t CT_TERM5 = 8'hd2;
	localparam ctrl_type_t CT_TERM6 = 8'he1;
	localparam ctrl_type_t CT_TERM7 = 8'hff;
	// Ordered sets, A and B carry the set in the upper half, C in the lower
	localparam ctrl_type_t CT_OS_A  = 8'h2d;
	localparam ctrl_type_t CT_OS_B  = 8'h55;
	localparam ctrl_type_t CT_OS_C  = 8'h4b;
	localparam ctrl_type_t CT_IDLE  = 8'h1e;

	// Start type, six preamble bytes, then the SFD in the top lane
	localparam logic [BLOCK_W-1:0] PREAMBLE_BLOCK =
		{8'hd5, 48'h5555_5555_5555, CT_START, SYNC_CONTROL};

	localparam logic [23:0] REMOTE_FAULT_SEQ = {8'h02, 8'h00, 8'h00};

	// Payload bytes carried by a terminate block
	function automatic logic [BYTES_W-1:0] term_bytes(input ctrl_type_t ct);
		case (ct)
		CT_TERM1: term_bytes = 3'd1;
		CT_TERM2: term_bytes = 3'd2;
		CT_TERM3: term_bytes = 3'd3;
		CT_TERM4: term_bytes = 3'd4;
		CT_TERM5: term_bytes = 3'd5;
		CT_TERM6: term_bytes = 3'd6;
		CT_TERM7: term_bytes = 3'd7;
		default:  term_bytes = 3'd0;
		endcase
	endfunction

endpackage

// ==== p64_frame_decoder.sv ====
/*
 * Frame decoder
 * Finds the preamble, decodes data and terminate blocks and holds one beat
 * back so that the last flag lands on the true last beat
 */
module p64_frame_decoder (
	input  logic                          RX_CLK,
	input  logic                          S_ARESETN,
	input  logic                          i_rx_valid,
	input  logic [p64_pkg::BLOCK_W-1:0]   i_rx_data,
	input  logic                          i_out_busy,
	input  logic                          i_phy_fault,
	output logic                          o_cand_valid,
	output logic [p64_pkg::DATA_W-1:0]    o_cand_data,
	output logic [p64_pkg::BYTES_W:0]     o_cand_bytes,
	output logic                          o_cand_last,
	output logic                          o_cand_release,
	output logic                          o_frame_error
);
	import p64_pkg::*;

	logic                in_pkt;
	// One-beat delay stage
	logic                dly_valid;
	logic                dly_last;
	logic [DATA_W-1:0]   dly_data;
	logic [BYTES_W:0]    dly_bytes;

	sync_t               blk_sync;
	ctrl_type_t          blk_type;
	logic                is_term;
	logic [BYTES_W-1:0]  term_k;
	logic [DATA_W-1:0]   term_data;
	logic                take_data;
	logic                take_term;
	logic                bad_blk;
	logic                start;
	logic                overflow;

	////////////////////////////////////////
	// Block classification
	////////////////////////////////////////
	always_comb
	begin
		blk_sync = sync_t'(i_rx_data[1:0]);
		blk_type = ctrl_type_t'(i_rx_data[9:2]);
		case (blk_type)
		CT_TERM0, CT_TERM1, CT_TERM2, CT_TERM3,
		CT_TERM4, CT_TERM5, CT_TERM6, CT_TERM7:
			is_term = 1'b1;
		default:
			is_term = 1'b0;
		endcase
		term_k = term_bytes(blk_type);
		// Drop the type byte, clear lanes past the end of the packet
		term_data = {8'h00, i_rx_data[BLOCK_W-1:10]}
			& ~({DATA_W{1'b1}} << {term_k, 3'b000});
	end

	assign take_data = i_rx_valid && in_pkt && (blk_sync == SYNC_DATA);
	assign take_term = i_rx_valid && in_pkt && (blk_sync == SYNC_CONTROL) && is_term;
	// Anything else inside a packet ends it as an error
	assign bad_blk   = i_rx_valid && in_pkt && !take_data && !take_term;

	// New packet only with an empty delay stage and a free output
	assign start = i_rx_valid && !in_pkt && (i_rx_data == PREAMBLE_BLOCK)
		&& !dly_valid && !i_out_busy;

	// Held beat leaves on every load, or on its own once marked last
	assign o_cand_release = dly_valid && (dly_last || take_data || take_term);
	assign overflow       = o_cand_release && i_out_busy;

	////////////////////////////////////////
	// Packet state and delay stage control
	////////////////////////////////////////
	always_ff @(posedge RX_CLK or negedge S_ARESETN)
	begin
		if (!S_ARESETN)
		begin
			in_pkt    <= 1'b0;
			dly_valid <= 1'b0;
			dly_last  <= 1'b0;
		end
		else if (i_phy_fault || overflow || bad_blk)
		begin
			// Drop the packet and wait for the next preamble
			in_pkt    <= 1'b0;
			dly_valid <= 1'b0;
			dly_last  <= 1'b0;
		end
		else
		begin
			if (start)
				in_pkt <= 1'b1;
			else if (take_term)
				in_pkt <= 1'b0;

			if (take_data)
			begin
				dly_valid <= 1'b1;
				dly_last  <= 1'b0;
			end
			else if (take_term && term_k != '0)
			begin
				dly_valid <= 1'b1;
				dly_last  <= 1'b1;
			end
			else if (o_cand_release)
			begin
				dly_valid <= 1'b0;
				dly_last  <= 1'b0;
			end
		end
	end

	// Beat payload
	always_ff @(posedge RX_CLK)
	begin
		if (take_data)
		begin
			dly_data  <= i_rx_data[BLOCK_W-1:2];
			dly_bytes <= 4'd8;
		end
		else if (take_term)
		begin
			dly_data  <= term_data;
			dly_bytes <= {1'b0, term_k};
		end
	end

	assign o_cand_valid = dly_valid;
	assign o_cand_data  = dly_data;
	assign o_cand_bytes = dly_bytes;
	// An empty terminate makes the held beat the last one right away
	assign o_cand_last   = dly_last || (take_term && term_k == '0);
	assign o_frame_error = bad_blk;

endmodule

// ==== p64_fault_monitor.sv ====
/*
 * Fault monitor
 * Synchronizes the PHY fault, decodes remote fault ordered sets and
 * produces a stretched local fault
 */
module p64_fault_monitor #(
	parameter int STRETCH_W = 4
) (
	input  logic                          RX_CLK,
	input  logic                          S_ARESETN,
	input  logic                          i_rx_valid,
	input  logic [p64_pkg::BLOCK_W-1:0]   i_rx_data,
	input  logic                          i_phy_fault,
	output logic                          o_phy_fault_sync,
	output logic                          o_local_fault_now,
	output logic                          o_remote_fault,
	output logic                          o_local_fault
);
	import p64_pkg::*;

	logic [2:0]           fault_pipe;
	logic                 powering_up;
	logic [STRETCH_W-1:0] stretch_cnt;
	sync_t                blk_sync;
	ctrl_type_t           blk_type;
	// Ordered set matches in either half of the block
	logic                 rf_hi;
	logic                 rf_lo;

	assign blk_sync = sync_t'(i_rx_data[1:0]);
	assign blk_type = ctrl_type_t'(i_rx_data[9:2]);
	assign rf_hi    = (i_rx_data[65:42] == REMOTE_FAULT_SEQ);
	assign rf_lo    = (i_rx_data[33:10] == REMOTE_FAULT_SEQ);

	// Three-flop synchronizer, starts out faulted
	always_ff @(posedge RX_CLK or negedge S_ARESETN)
	begin
		if (!S_ARESETN)
			fault_pipe <= '1;
		else
			fault_pipe <= {fault_pipe[1:0], i_phy_fault};
	end
	assign o_phy_fault_sync = fault_pipe[2];

	// Held until a clean block arrives with the PHY out of fault
	always_ff @(posedge RX_CLK or negedge S_ARESETN)
	begin
		if (!S_ARESETN)
			powering_up <= 1'b1;
		else if (i_rx_valid && !o_phy_fault_sync)
			powering_up <= 1'b0;
	end

	////////////////////////////////////////
	// Fault decode per valid block
	////////////////////////////////////////
	always_ff @(posedge RX_CLK or negedge S_ARESETN)
	begin
		if (!S_ARESETN)
		begin
			o_remote_fault    <= 1'b0;
			o_local_fault_now <= 1'b0;
		end
		else if (i_rx_valid)
		begin
			o_remote_fault    <= 1'b0;
			o_local_fault_now <= 1'b0;
			if (blk_sync == SYNC_CONTROL)
			begin
				case (blk_type)
				CT_OS_A, CT_OS_B:
				begin
					o_remote_fault    <= rf_hi;
					o_local_fault_now <= !rf_hi;
				end
				CT_OS_C:
				begin
					o_remote_fault    <= rf_lo;
					o_local_fault_now <= !rf_lo;
				end
				CT_IDLE, CT_START, CT_TERM0, CT_TERM1, CT_TERM2,
				CT_TERM3, CT_TERM4, CT_TERM5, CT_TERM6, CT_TERM7:
					o_local_fault_now <= 1'b0;
				// Unknown control type
				default:
					o_local_fault_now <= 1'b1;
				endcase
			end
			else if (blk_sync != SYNC_DATA)
				// Sync header 00 or 11
				o_local_fault_now <= 1'b1;
		end
	end

	// Stretch, reloads on every fault and during power-up
	always_ff @(posedge RX_CLK or negedge S_ARESETN)
	begin
		if (!S_ARESETN)
			stretch_cnt <= '1;
		else if (powering_up || o_local_fault_now)
			stretch_cnt <= '1;
		else if (stretch_cnt != '0)
			stretch_cnt <= stretch_cnt - 1'b1;
	end

	assign o_local_fault = powering_up || o_local_fault_now || (stretch_cnt != '0);

endmodule

// ==== p64_beat_output.sv ====
/*
 * Beat output stage
 * Registers released beats onto the packet stream and generates abort
 */
module p64_beat_output (
	input  logic                          RX_CLK,
	input  logic                          S_ARESETN,
	input  logic                          i_cand_valid,
	input  logic [p64_pkg::DATA_W-1:0]    i_cand_data,
	input  logic [p64_pkg::BYTES_W:0]     i_cand_bytes,
	input  logic                          i_cand_last,
	input  logic                          i_cand_release,
	input  logic                          i_frame_error,
	input  logic                          i_local_fault_now,
	input  logic                          i_phy_fault_sync,
	input  logic                          i_m_ready,
	output logic                          o_m_valid,
	output logic [p64_pkg::DATA_W-1:0]    o_m_data,
	output logic [p64_pkg::BYTES_W-1:0]   o_m_bytes,
	output logic                          o_m_last,
	output logic                          o_m_abort,
	output logic                          o_out_busy
);
	import p64_pkg::*;

	// Beats of the current packet have gone out, last not yet
	logic pkt_open;
	logic load;
	logic abort_set;

	assign o_out_busy = o_m_valid && !i_m_ready;
	assign load       = i_cand_release && !o_out_busy;

	// Error or fault while a packet is open, or a beat with nowhere to go
	assign abort_set = ((pkt_open || i_cand_valid)
			&& (i_frame_error || i_local_fault_now || i_phy_fault_sync))
		|| (i_cand_release && o_out_busy);

	always_ff @(posedge RX_CLK or negedge S_ARESETN)
	begin
		if (!S_ARESETN)
		begin
			o_m_valid <= 1'b0;
			o_m_abort <= 1'b0;
			pkt_open  <= 1'b0;
		end
		else
		begin
			if (load)
				o_m_valid <= 1'b1;
			else if (i_m_ready)
				o_m_valid <= 1'b0;

			// Abort holds until the stalled beat is gone
			if (abort_set)
				o_m_abort <= 1'b1;
			else if (!o_out_busy)
				o_m_abort <= 1'b0;

			if (abort_set)
				pkt_open <= 1'b0;
			else if (load)
				pkt_open <= !i_cand_last;
		end
	end

	// Stream payload, held while stalled
	always_ff @(posedge RX_CLK)
	begin
		if (load)
		begin
			o_m_data  <= i_cand_data;
			// Full beat of eight folds to zero
			o_m_bytes <= i_cand_bytes[BYTES_W] ? '0 : i_cand_bytes[BYTES_W-1:0];
			o_m_last  <= i_cand_last;
		end
	end

endmodule

// ==== p64_rx_top.sv ====
/*
 * 10G block receiver top
 * Frame decoder and fault monitor side by side, joined in the output stage
 */
module p64_rx_top #(
	parameter int STRETCH_W = 4
) (
	input  logic                          RX_CLK,
	input  logic                          S_ARESETN,
	input  logic                          i_phy_fault,
	input  logic                          i_rx_valid,
	input  logic [p64_pkg::BLOCK_W-1:0]   i_rx_data,
	input  logic                          i_m_ready,
	output logic                          o_m_valid,
	output logic [p64_pkg::DATA_W-1:0]    o_m_data,
	output logic [p64_pkg::BYTES_W-1:0]   o_m_bytes,
	output logic                          o_m_last,
	output logic                          o_m_abort,
	output logic                          o_remote_fault,
	output logic                          o_local_fault
);
	import p64_pkg::*;

	// Decoder to output stage
	logic                cand_valid;
	logic [DATA_W-1:0]   cand_data;
	logic [BYTES_W:0]    cand_bytes;
	logic                cand_last;
	logic                cand_release;
	logic                frame_error;
	// Monitor results
	logic                local_fault_now;
	logic                phy_fault_sync;
	// Output stage back to decoder
	logic                out_busy;

	// Decoder sees the synchronized PHY fault
	p64_frame_decoder p64_frame_decoder_i (
		.RX_CLK         (RX_CLK),
		.S_ARESETN      (S_ARESETN),
		.i_rx_valid     (i_rx_valid),
		.i_rx_data      (i_rx_data),
		.i_out_busy     (out_busy),
		.i_phy_fault    (phy_fault_sync),
		.o_cand_valid   (cand_valid),
		.o_cand_data    (cand_data),
		.o_cand_bytes   (cand_bytes),
		.o_cand_last    (cand_last),
		.o_cand_release (cand_release),
		.o_frame_error  (frame_error)
	);

	p64_fault_monitor #(
		.STRETCH_W (STRETCH_W)
	) p64_fault_monitor_i (
		.RX_CLK            (RX_CLK),
		.S_ARESETN         (S_ARESETN),
		.i_rx_valid        (i_rx_valid),
		.i_rx_data         (i_rx_data),
		.i_phy_fault       (i_phy_fault),
		.o_phy_fault_sync  (phy_fault_sync),
		.o_local_fault_now (local_fault_now),
		.o_remote_fault    (o_remote_fault),
		.o_local_fault     (o_local_fault)
	);

	p64_beat_output p64_beat_output_i (
		.RX_CLK            (RX_CLK),
		.S_ARESETN         (S_ARESETN),
		.i_cand_valid      (cand_valid),
		.i_cand_data       (cand_data),
		.i_cand_bytes      (cand_bytes),
		.i_cand_last       (cand_last),
		.i_cand_release    (cand_release),
		.i_frame_error     (frame_error),
		.i_local_fault_now (local_fault_now),
		.i_phy_fault_sync  (phy_fault_sync),
		.i_m_ready         (i_m_ready),
		.o_m_valid         (o_m_valid),
		.o_m_data          (o_m_data),
		.o_m_bytes         (o_m_bytes),
		.o_m_last          (o_m_last),
		.o_m_abort         (o_m_abort),
		.o_out_busy        (out_busy)
	);

endmodule

// ==== p64_rx_asserts.sv ====
/*
 * Output stream protocol checks
 * Bound to the beat output stage
 */
module p64_rx_asserts (
	input  logic                          RX_CLK,
	input  logic                          S_ARESETN,
	input  logic                          i_m_valid,
	input  logic                          i_m_ready,
	input  logic [p64_pkg::DATA_W-1:0]    i_m_data,
	input  logic [p64_pkg::BYTES_W-1:0]   i_m_bytes,
	input  logic                          i_m_last
);

	// Stalled beat holds its payload
	stall_stable: assert property (@(posedge RX_CLK) disable iff (!S_ARESETN)
		(i_m_valid && !i_m_ready) |=> (i_m_valid && $stable(i_m_data)
			&& $stable(i_m_bytes) && $stable(i_m_last)))
		else $error("stalled beat changed before transfer");

	// No beat offered while in reset
	reset_quiet: assert property (@(posedge RX_CLK)
		!S_ARESETN |-> !i_m_valid)
		else $error("m_valid high during reset");

	// Partial byte counts only on the last beat
	bytes_last: assert property (@(posedge RX_CLK) disable iff (!S_ARESETN)
		(i_m_valid && i_m_bytes != '0) |-> i_m_last)
		else $error("partial byte count on a beat without last");

endmodule

// ==== tb_p64_rx.sv ====
/*
 * Testbench for the 10G block receiver
 * Random packets, stalls, bad blocks and faults against a reference beat list
 */
module tb_p64_rx;
	import p64_pkg::*;

	localparam int STRETCH_W     = 4;
	localparam int CLK_PERIOD    = 40;
	localparam int NUM_RAND_PKTS = 12;
	// Both random runs plus two aborted and two recovery packets
	localparam int NUM_PKTS      = 2 * NUM_RAND_PKTS + 4;
	// Watchdog budget of 200 cycles for each packet sent
	localparam int TIMEOUT_CYCLES = NUM_PKTS * 200;

	logic                RX_CLK = 1'b0;
	logic                S_ARESETN;
	logic                phy_fault;
	logic                rx_valid;
	logic [BLOCK_W-1:0]  rx_data;
	logic                m_ready;
	logic                m_valid;
	logic [DATA_W-1:0]   m_data;
	logic [BYTES_W-1:0]  m_bytes;
	logic                m_last;
	logic                m_abort;
	logic                remote_fault;
	logic                local_fault;

	// Expected beats from the reference function
	logic [DATA_W-1:0]   exp_data[$];
	logic [BYTES_W-1:0]  exp_bytes[$];
	logic                exp_last[$];
	int                  cyc = 0;
	int                  term_cycle;
	int                  exp_lat;
	int                  pkts_done = 0;
	// Intact packets handed to the DUT
	int                  pkts_sent = 0;
	int                  errors = 0;
	bit                  lat_check = 1'b0;
	// Set while a packet is expected to be aborted
	bit                  chk_mode = 1'b0;
	bit                  abort_seen = 1'b0;
	logic                ready_lvl = 1'b1;
	int unsigned         seed_val;

	p64_rx_top #(
		.STRETCH_W (STRETCH_W)
	) p64_rx_top_i (
		.RX_CLK         (RX_CLK),
		.S_ARESETN      (S_ARESETN),
		.i_phy_fault    (phy_fault),
		.i_rx_valid     (rx_valid),
		.i_rx_data      (rx_data),
		.i_m_ready      (m_ready),
		.o_m_valid      (m_valid),
		.o_m_data       (m_data),
		.o_m_bytes      (m_bytes),
		.o_m_last       (m_last),
		.o_m_abort      (m_abort),
		.o_remote_fault (remote_fault),
		.o_local_fault  (local_fault)
	);

	bind p64_beat_output p64_rx_asserts p64_rx_asserts_i (
		.RX_CLK    (RX_CLK),
		.S_ARESETN (S_ARESETN),
		.i_m_valid (o_m_valid),
		.i_m_ready (i_m_ready),
		.i_m_data  (o_m_data),
		.i_m_bytes (o_m_bytes),
		.i_m_last  (o_m_last)
	);

	always #(CLK_PERIOD / 2) RX_CLK = ~RX_CLK;

	always @(posedge RX_CLK)
		cyc <= cyc + 1;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// Full beats of eight bytes and the remainder in the last beat
	function automatic void build_expected(input int n, input logic [7:0] pkt[$]);
		int nbeats;
		int cnt;
		logic [DATA_W-1:0] d;
		nbeats = (n + 7) / 8;
		for (int b = 0; b < nbeats; b++)
		begin
			cnt = (n - 8 * b > 8) ? 8 : n - 8 * b;
			d = '0;
			for (int j = 0; j < cnt; j++)
				d[8*j +: 8] = pkt[8*b + j];
			exp_data.push_back(d);
			exp_bytes.push_back((cnt == 8) ? 3'd0 : 3'(cnt));
			exp_last.push_back(b == nbeats - 1);
		end
	endfunction

	function automatic logic [7:0] term_code(input int k);
		case (k)
		1:       term_code = CT_TERM1;
		2:       term_code = CT_TERM2;
		3:       term_code = CT_TERM3;
		4:       term_code = CT_TERM4;
		5:       term_code = CT_TERM5;
		6:       term_code = CT_TERM6;
		7:       term_code = CT_TERM7;
		default: term_code = CT_TERM0;
		endcase
	endfunction

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////
	task automatic drive_block(input logic [BLOCK_W-1:0] blk);
		rx_valid <= 1'b1;
		rx_data  <= blk;
		m_ready  <= ready_lvl;
		@(posedge RX_CLK);
	endtask

	task automatic drive_gap(input logic rdy);
		rx_valid <= 1'b0;
		m_ready  <= rdy;
		@(posedge RX_CLK);
	endtask

	// Idle cycles between blocks where the stalls land
	task automatic stall_gaps(input bit stall);
		if (stall)
			repeat ($urandom % 3) drive_gap(1'($urandom));
	endtask

	task automatic wait_packets(input int target, input bit stall);
		while (pkts_done < target)
			drive_gap(stall ? 1'($urandom) : 1'b1);
		repeat (3) drive_gap(1'b1);
	endtask

	function automatic logic [BLOCK_W-1:0] data_block(input logic [7:0] pkt[$], input int b);
		logic [BLOCK_W-1:0] blk;
		blk[1:0] = SYNC_DATA;
		for (int j = 0; j < 8; j++)
			blk[2 + 8*j +: 8] = pkt[8*b + j];
		return blk;
	endfunction

	task automatic send_packet(input int n, input bit stall);
		logic [7:0]         pkt[$];
		logic [BLOCK_W-1:0] blk;
		logic [63:0]        fill;
		int                 rem;
		pkts_sent++;
		for (int i = 0; i < n; i++)
			pkt.push_back(8'($urandom));
		build_expected(n, pkt);
		rem = n % 8;
		drive_block(PREAMBLE_BLOCK);
		stall_gaps(stall);
		for (int b = 0; b < n / 8; b++)
		begin
			drive_block(data_block(pkt, b));
			stall_gaps(stall);
		end
		// Unused terminate lanes carry junk that must not come out
		fill = {$urandom, $urandom};
		blk = {fill[55:0], term_code(rem), SYNC_CONTROL};
		for (int j = 0; j < rem; j++)
			blk[10 + 8*j +: 8] = pkt[8*(n/8) + j];
		term_cycle = cyc + 1;
		exp_lat = (rem == 0) ? 1 : 2;
		drive_block(blk);
		drive_gap(1'b1);
	endtask

	////////////////////////////////////////
	// Compare process
	////////////////////////////////////////
	always @(posedge RX_CLK)
	begin
		if (S_ARESETN && chk_mode)
		begin
			if (m_abort)
				abort_seen = 1'b1;
			if (m_valid && m_ready && m_last)
				fail_run("a beat with the last flag came out of an aborted packet");
		end
		else if (S_ARESETN)
		begin
			check_value("m_abort", 64'(m_abort), 64'd0);
			if (m_valid && m_ready && exp_data.size() == 0)
				fail_run("a beat came out that no packet expected");
			else if (m_valid && m_ready)
			begin
				check_value("m_data", m_data, exp_data.pop_front());
				check_value("m_bytes", 64'(m_bytes), 64'(exp_bytes.pop_front()));
				check_value("m_last", 64'(m_last), 64'(exp_last.pop_front()));
				if (m_last && lat_check)
					check_value("last beat latency", 64'(cyc - term_cycle), 64'(exp_lat));
				if (m_last)
					pkts_done++;
			end
		end
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all tests finished");
		$display("Test failed");
		$fatal(1);
	end

	initial
	begin
		logic [BLOCK_W-1:0] os_blk;
		logic [7:0]         pkt[$];
		int                 n;
		seed_val  = $urandom(32'hf0fde4cf);
		S_ARESETN = 1'b0;
		phy_fault = 1'b0;
		rx_valid  = 1'b0;
		rx_data   = '0;
		m_ready   = 1'b1;
		repeat (4) @(posedge RX_CLK);
		// Reset values sampled while still in reset
		check_value("m_valid", 64'(m_valid), 64'd0);
		check_value("m_abort", 64'(m_abort), 64'd0);
		check_value("remote_fault", 64'(remote_fault), 64'd0);
		check_value("local_fault", 64'(local_fault), 64'd1);
		S_ARESETN <= 1'b1;
		repeat (4) drive_gap(1'b1);

		// Idle blocks clear the power-up local fault
		n = 0;
		while (local_fault && n < 2 ** STRETCH_W + 2)
		begin
			drive_block({56'h0, CT_IDLE, SYNC_CONTROL});
			n++;
		end
		if (local_fault)
			fail_run("local fault did not clear after idle blocks");

		// Back to back packets with ready held high
		lat_check = 1'b1;
		for (int p = 0; p < NUM_RAND_PKTS; p++)
		begin
			send_packet(8 + int'($urandom % 57), 1'b0);
			wait_packets(pkts_sent, 1'b0);
		end
		lat_check = 1'b0;

		// Gaps and stalls
		for (int p = 0; p < NUM_RAND_PKTS; p++)
		begin
			send_packet(8 + int'($urandom % 57), 1'b1);
			wait_packets(pkts_sent, 1'b1);
		end

		// Unknown control type mid-packet
		chk_mode = 1'b1;
		abort_seen = 1'b0;
		for (int i = 0; i < 24; i++)
			pkt.push_back(8'($urandom));
		drive_block(PREAMBLE_BLOCK);
		drive_block(data_block(pkt, 0));
		drive_block(data_block(pkt, 1));
		drive_block({56'h0, 8'h00, SYNC_CONTROL});
		repeat (4) drive_gap(1'b1);
		check_value("abort_seen", 64'(abort_seen), 64'd1);
		check_value("local_fault", 64'(local_fault), 64'd1);
		repeat (4) drive_gap(1'b1);
		chk_mode = 1'b0;
		send_packet(40, 1'b0);
		wait_packets(pkts_sent, 1'b0);

		// Remote fault ordered set followed by idle
		os_blk = {REMOTE_FAULT_SEQ, 32'h0, CT_OS_A, SYNC_CONTROL};
		drive_block(os_blk);
		drive_gap(1'b1);
		check_value("remote_fault", 64'(remote_fault), 64'd1);
		drive_block({56'h0, CT_IDLE, SYNC_CONTROL});
		drive_gap(1'b1);
		check_value("remote_fault", 64'(remote_fault), 64'd0);

		// Ready held low through a packet
		chk_mode = 1'b1;
		abort_seen = 1'b0;
		ready_lvl = 1'b0;
		drive_block(PREAMBLE_BLOCK);
		for (int b = 0; b < 3; b++)
			drive_block(data_block(pkt, b));
		drive_block({56'h0, CT_TERM0, SYNC_CONTROL});
		repeat (3) drive_gap(1'b0);
		check_value("abort_seen", 64'(abort_seen), 64'd1);
		check_value("m_abort", 64'(m_abort), 64'd1);
		ready_lvl = 1'b1;
		repeat (6) drive_gap(1'b1);
		chk_mode = 1'b0;
		send_packet(29, 1'b0);
		wait_packets(pkts_sent, 1'b0);

		if (errors == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

// ==== sim.f ====
p64_pkg.sv
p64_frame_decoder.sv
p64_fault_monitor.sv
p64_beat_output.sv
p64_rx_top.sv
p64_rx_asserts.sv
tb_p64_rx.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert --timing
TOP       := tb_p64_rx
FLIST     := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
